// ==== files.f ====
+incdir+.
eg_pkg.sv
eg_ctrl.sv
eg_step.sv
eg_update.sv
eg_top.sv
tb_eg.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing -f files.f --top-module tb_eg
	./obj_dir/Vtb_eg | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_eg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eg_defines.svh"

module tb_eg import eg_pkg::*; ();

	logic clk;
	logic rst_n;
	logic cfg_valid;
	logic cfg_ready;
	eg_op_t cfg_op;
	logic [2:0] cfg_sel;
	logic [4:0] cfg_data;
	logic key_valid;
	logic key_ready;
	eg_op_t key_op;
	logic key_on;
	logic out_valid;
	logic out_ready;
	eg_op_t out_op;
	eg_att_t out_att;
	logic out_pg_rst;

	// reference model with one entry per operator
	eg_state_t m_st [`EG_OPS];
	eg_att_t m_att [`EG_OPS];
	logic m_inv [`EG_OPS];
	logic m_lock [`EG_OPS];
	logic m_keyed [`EG_OPS];
	logic m_kon [`EG_OPS];
	logic m_koff [`EG_OPS];
	eg_rate_t m_ar [`EG_OPS];
	eg_rate_t m_d1r [`EG_OPS];
	eg_rate_t m_d2r [`EG_OPS];
	logic [3:0] m_rr [`EG_OPS];
	logic [3:0] m_sl [`EG_OPS];
	logic [3:0] m_ssg [`EG_OPS]; // enable, attack, alternate, hold
	eg_op_t m_slot;
	int m_cnt; // samples done so far

	// expected results on their way to the output port
	eg_op_t q_op [$];
	eg_att_t q_att [$];
	logic q_pg [$];

	eg_att_t goal_att [`EG_OPS]; // level each operator is waited for
	logic reached [`EG_OPS]; // goal level seen at the port since it was set
	eg_op_t seq_op; // slot order seen at the port
	logic held_valid;
	eg_op_t held_op;
	eg_att_t held_att;
	logic held_pg;
	logic cfg_acc;
	logic key_acc;
	int n_out;
	int stall_pct;
	logic [31:0] rng;

	eg_top dut_i (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// uniform in lo..hi
	function automatic int rnd(input int lo, input int hi);
		logic [31:0] r;
		r = next_rand();
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	// step spacing halves every two rates
	function automatic void rate_step(input eg_rate_t r, input int cnt, output logic stp,
			output int inc);
		int shift;
		shift = 11 - int'(r) / 2;
		inc = 1;
		stp = 1'b1;
		if (r == 5'd0) stp = 1'b0; // frozen
		else if (int'(r) >= 28) inc = 4;
		else if (int'(r) >= 24) inc = 2;
		else stp = (cnt % (1 << shift)) == 0;
	endfunction

	// one slot of the envelope and its expected port result
	function automatic void model_fire();
		eg_op_t op;
		eg_state_t st;
		eg_state_t nst;
		eg_rate_t rate;
		logic kon, koff, en, alt, hold, over, pg, stp, ninv, nlock;
		int att, natt, lvl, sus, inc;
		op = m_slot;
		st = m_st[op];
		att = int'(m_att[op]);
		kon = m_kon[op] && !m_keyed[op];
		koff = m_koff[op] && m_keyed[op];
		en = m_ssg[op][3];
		alt = m_ssg[op][1];
		hold = m_ssg[op][0] && en;
		over = en && att >= 512; // past halfway
		sus = (m_sl[op] == 4'd15) ? 31 : int'(m_sl[op]);
		pg = kon || (over && !alt && !hold);
		nst = st;
		rate = 5'd0;
		ninv = m_inv[op];
		nlock = m_lock[op];
		if (koff) begin
			nst = RELEASE;
			rate = eg_rate_t'(2 * int'(m_rr[op]) + 1);
			ninv = m_inv[op] && en;
			nlock = 1'b0;
		end else if (kon) begin
			nst = ATTACK;
			rate = m_ar[op];
			ninv = m_ssg[op][2] && en; // start polarity
			nlock = 1'b0;
		end else if (st == ATTACK && att == 0) begin
			nst = m_lock[op] ? HOLD : DECAY;
			rate = m_lock[op] ? 5'd0 : m_d1r[op];
			ninv = en && (alt != m_inv[op]);
			nlock = hold;
		end else if (st == ATTACK) begin
			rate = m_ar[op];
		end else if (st == DECAY && over) begin
			nst = ATTACK; // SSG restart
			rate = m_ar[op];
			nlock = hold;
		end else if (st == DECAY) begin
			rate = ((att >> 5) >= sus) ? m_d2r[op] : m_d1r[op];
			nlock = 1'b0;
		end else if (st == HOLD) begin
			nlock = 1'b1;
		end else begin
			rate = eg_rate_t'(2 * int'(m_rr[op]) + 1);
			ninv = 1'b0;
			nlock = 1'b0;
		end
		rate_step(rate, m_cnt, stp, inc);
		natt = att;
		if (nst == ATTACK && m_ar[op] == 5'd31) begin
			natt = 0;
		end else if (nst == ATTACK && stp) begin
			natt = att - (att / 16 + 1) * inc;
			if (natt < 0) natt = 0;
		end else if ((nst == DECAY || nst == RELEASE) && stp) begin
			natt = att + (en ? 4 * inc : inc);
			if (natt > 1023) natt = 1023;
		end
		lvl = att; // port shows the level before this update
		if (m_inv[op]) lvl = (att >= 512) ? 0 : 512 - att;
		q_op.push_back(op);
		q_att.push_back(eg_att_t'(lvl));
		q_pg.push_back(pg);
		m_st[op] = nst;
		m_att[op] = eg_att_t'(natt);
		m_inv[op] = ninv;
		m_lock[op] = nlock;
		m_kon[op] = 1'b0;
		m_koff[op] = 1'b0;
		if (kon) m_keyed[op] = 1'b1;
		if (koff) m_keyed[op] = 1'b0;
		if (op == eg_op_t'(`EG_OPS - 1)) m_cnt++;
		m_slot = op + eg_op_t'(1);
	endfunction

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_op(input eg_op_t got, input eg_op_t exp, input string what);
		if (got !== exp) begin
			$display("error at %0t ns: %s out_op is %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_att(input eg_att_t got, input eg_att_t exp, input string what);
		if (got !== exp) begin
			$display("error at %0t ns: %s out_att is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_pg_rst(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("error at %0t ns: %s out_pg_rst is %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_low(input logic got, input string what);
		if (got !== 1'b0) begin
			$display("error at %0t ns: %s is %b during reset, expected 0", $time, what, got);
			stop_run();
		end
	endtask

	// mid-cycle look at the port before modelling the coming edge
	task automatic observe();
		logic v;
		v = out_valid;
		if (held_valid) begin // data must hold after a stall
			check_op(out_op, held_op, "stalled");
			check_att(out_att, held_att, "stalled");
			check_pg_rst(out_pg_rst, held_pg, "stalled");
		end
		if (v && out_ready) begin
			if (q_op.size() == 0) begin
				$display("output handshake at %0t ns with no result expected", $time);
				stop_run();
			end
			check_op(out_op, q_op.pop_front(), "model");
			check_att(out_att, q_att.pop_front(), "model");
			check_pg_rst(out_pg_rst, q_pg.pop_front(), "model");
			check_op(out_op, seq_op, "slot order");
			seq_op = seq_op + eg_op_t'(1);
			if (out_att == goal_att[out_op]) reached[out_op] = 1'b1;
			n_out++;
		end
		held_valid = v && !out_ready;
		held_op = out_op;
		held_att = out_att;
		held_pg = out_pg_rst;
		if (!v || out_ready) model_fire(); // slot fires on this edge
		// port sets land after the slot clear
		if (key_valid && key_ready) begin
			if (key_on) m_kon[key_op] = 1'b1;
			else m_koff[key_op] = 1'b1;
			key_acc = 1'b1;
		end
		if (cfg_valid && cfg_ready) begin
			case (cfg_sel)
				3'd0: m_ar[cfg_op] = cfg_data;
				3'd1: m_d1r[cfg_op] = cfg_data;
				3'd2: m_d2r[cfg_op] = cfg_data;
				3'd3: m_rr[cfg_op] = cfg_data[3:0];
				3'd4: m_sl[cfg_op] = cfg_data[3:0];
				3'd5: m_ssg[cfg_op] = cfg_data[3:0];
				default: ;
			endcase
			cfg_acc = 1'b1;
		end
	endtask

	task automatic tick();
		@(negedge clk);
		observe();
		@(posedge clk);
		#1;
		out_ready = rnd(0, 99) >= stall_pct; // random back-pressure
	endtask

	task automatic write_cfg(input eg_op_t op, input logic [2:0] sel, input logic [4:0] data);
		int n;
		cfg_op = op;
		cfg_sel = sel;
		cfg_data = data;
		cfg_valid = 1'b1;
		cfg_acc = 1'b0;
		for (n = 0; n < 50 && !cfg_acc; n++) tick();
		cfg_valid = 1'b0;
		if (!cfg_acc) begin
			$display("config write to operator %0d was never accepted", op);
			stop_run();
		end
	endtask

	task automatic send_key(input eg_op_t op, input logic on);
		int n;
		key_op = op;
		key_on = on;
		key_valid = 1'b1;
		key_acc = 1'b0;
		for (n = 0; n < 50 && !key_acc; n++) tick();
		key_valid = 1'b0;
		if (!key_acc) begin
			$display("key event for operator %0d was never accepted", op);
			stop_run();
		end
	endtask

	// start looking for a level at the port
	task automatic watch_level(input eg_op_t op, input eg_att_t target);
		goal_att[op] = target;
		reached[op] = 1'b0;
	endtask

	// run until the operator has shown its watched level
	task automatic wait_level(input eg_op_t op, input int limit);
		int n;
		for (n = 0; n < limit && !reached[op]; n++) tick();
		if (!reached[op]) begin
			$display("operator %0d never reached level %h", op, goal_att[op]);
			stop_run();
		end
	endtask

	initial begin
		int i;
		int pick;
		clk = 1'b0;
		rst_n = 1'b0;
		cfg_valid = 1'b0;
		cfg_op = '0;
		cfg_sel = '0;
		cfg_data = '0;
		key_valid = 1'b0;
		key_op = '0;
		key_on = 1'b0;
		out_ready = 1'b0;
		rng = 32'd57207;
		stall_pct = 25;
		m_slot = '0;
		m_cnt = 0;
		seq_op = '0;
		held_valid = 1'b0;
		n_out = 0;
		for (i = 0; i < `EG_OPS; i++) begin
			m_st[i] = RELEASE;
			m_att[i] = 10'h3ff; // silent after reset
			m_inv[i] = 1'b0;
			m_lock[i] = 1'b0;
			m_keyed[i] = 1'b0;
			m_kon[i] = 1'b0;
			m_koff[i] = 1'b0;
			m_ar[i] = '0;
			m_d1r[i] = '0;
			m_d2r[i] = '0;
			m_rr[i] = '0;
			m_sl[i] = '0;
			m_ssg[i] = '0;
			goal_att[i] = '0;
			reached[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_low(out_valid, "out_valid");
		check_low(cfg_ready, "cfg_ready");
		check_low(key_ready, "key_ready");
		@(posedge clk);
		#1;
		rst_n = 1'b1;

		// plain envelopes with instant attack on op 0
		for (i = 0; i < `EG_OPS; i++) begin
			write_cfg(eg_op_t'(i), 3'd0, (i == 0) ? 5'd31 : 5'(rnd(20, 30)));
			write_cfg(eg_op_t'(i), 3'd1, 5'(rnd(20, 29)));
			write_cfg(eg_op_t'(i), 3'd2, 5'(rnd(16, 24)));
			write_cfg(eg_op_t'(i), 3'd3, 5'(rnd(11, 15)));
			write_cfg(eg_op_t'(i), 3'd4, 5'(rnd(1, 14)));
		end
		for (i = 0; i < `EG_OPS; i++) watch_level(eg_op_t'(i), '0); // peak
		for (i = 0; i < `EG_OPS; i++) send_key(eg_op_t'(i), 1'b1);
		for (i = 0; i < `EG_OPS; i++) wait_level(eg_op_t'(i), 20000);
		repeat (1500) tick(); // decay into sustain

		// release to silence and stay there
		for (i = 0; i < `EG_OPS; i++) watch_level(eg_op_t'(i), 10'h3ff);
		for (i = 0; i < `EG_OPS; i++) send_key(eg_op_t'(i), 1'b0);
		for (i = 0; i < `EG_OPS; i++) wait_level(eg_op_t'(i), 40000);
		repeat (200) tick();

		// SSG repeat, alternate, hold, inverted alternate
		write_cfg(eg_op_t'(0), 3'd5, 5'b01000);
		write_cfg(eg_op_t'(1), 3'd5, 5'b01010);
		write_cfg(eg_op_t'(2), 3'd5, 5'b01001);
		write_cfg(eg_op_t'(3), 3'd5, 5'b01110);
		for (i = 0; i < `EG_OPS; i++) begin
			write_cfg(eg_op_t'(i), 3'd1, 5'(rnd(22, 28)));
			write_cfg(eg_op_t'(i), 3'd4, 5'd15); // rate1 all the way up to overflow
		end
		for (i = 0; i < `EG_OPS; i++) send_key(eg_op_t'(i), 1'b1);
		repeat (3000) tick();

		// random traffic under heavy stalls
		stall_pct = 60;
		for (i = 0; i < 300; i++) begin
			pick = rnd(0, 9);
			if (pick < 3) write_cfg(eg_op_t'(rnd(0, `EG_OPS - 1)), 3'(rnd(0, 5)), 5'(rnd(0, 31)));
			else if (pick < 5) send_key(eg_op_t'(rnd(0, `EG_OPS - 1)), rnd(0, 1) == 1);
			else repeat (rnd(1, 20)) tick();
		end

		if (n_out < 1000) begin
			$display("too few results left the output port: %0d", n_out);
			stop_run();
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== eg_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eg_defines.svh"

module eg_top import eg_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	// config writes
	input  wire         cfg_valid,
	output logic        cfg_ready,
	input  wire eg_op_t cfg_op,
	input  wire [2:0]   cfg_sel,
	input  wire [4:0]   cfg_data,
	// key events
	input  wire         key_valid,
	output logic        key_ready,
	input  wire eg_op_t key_op,
	input  wire         key_on,
	// one result per slot
	output logic        out_valid,
	input  wire         out_ready,
	output eg_op_t      out_op,
	output eg_att_t     out_att,
	output logic        out_pg_rst
);

	// per-operator state
	eg_state_t state_q [`EG_OPS];
	eg_att_t att_q [`EG_OPS];
	logic inv_q [`EG_OPS];
	logic lock_q [`EG_OPS];
	logic keyed_q [`EG_OPS];  // currently keyed on
	logic kon_q [`EG_OPS];    // pending key-on
	logic koff_q [`EG_OPS];   // pending key-off
	// per-operator config
	eg_rate_t ar_q [`EG_OPS];
	eg_rate_t d1r_q [`EG_OPS];
	eg_rate_t d2r_q [`EG_OPS];
	logic [3:0] rr_q [`EG_OPS];
	logic [3:0] sl_q [`EG_OPS];
	logic ssg_en_q [`EG_OPS];
	logic [2:0] ssg_eg_q [`EG_OPS];

	eg_op_t slot_q;
	logic port_rdy_q;
	logic fire;
	logic keyon_now;
	logic keyoff_now;
	eg_state_t state_next;
	eg_rate_t base_rate;
	logic ssg_inv_out;
	logic ssg_lock_out;
	logic pg_rst;
	logic step;
	logic [2:0] inc;
	eg_att_t att_next;
	eg_att_t level;

	assign fire = !out_valid || out_ready; // output register free
	assign cfg_ready = port_rdy_q;
	assign key_ready = port_rdy_q;
	assign keyon_now = kon_q[slot_q] & ~keyed_q[slot_q];
	assign keyoff_now = koff_q[slot_q] & keyed_q[slot_q];

	eg_ctrl ctrl_i (
		.keyon_now, .keyoff_now,
		.state_in(state_q[slot_q]), .att(att_q[slot_q]),
		.arate(ar_q[slot_q]), .rate1(d1r_q[slot_q]), .rate2(d2r_q[slot_q]),
		.rrate(rr_q[slot_q]), .sl(sl_q[slot_q]),
		.ssg_en(ssg_en_q[slot_q]), .ssg_eg(ssg_eg_q[slot_q]),
		.ssg_inv_in(inv_q[slot_q]), .ssg_lock_in(lock_q[slot_q]),
		.ssg_inv_out, .ssg_lock_out, .base_rate, .state_next, .pg_rst
	);

	// counter moves once per full round of slots
	eg_step step_i (
		.clk, .rst_n, .advance(fire && (slot_q == eg_op_t'(`EG_OPS - 1))),
		.base_rate, .step, .inc
	);

	eg_update update_i (
		.state(state_next), .att(att_q[slot_q]), .step, .inc,
		.ssg_en(ssg_en_q[slot_q]), .ssg_inv(inv_q[slot_q]),
		.arate(ar_q[slot_q]), .att_next, .level
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			port_rdy_q <= 1'b0;
			slot_q <= '0;
			out_valid <= 1'b0;
			for (int i = 0; i < `EG_OPS; i++) begin
				state_q[i] <= RELEASE;
				att_q[i] <= ATT_MAX; // silent
				inv_q[i] <= 1'b0;
				lock_q[i] <= 1'b0;
				keyed_q[i] <= 1'b0;
				kon_q[i] <= 1'b0;
				koff_q[i] <= 1'b0;
				ar_q[i] <= '0;
				d1r_q[i] <= '0;
				d2r_q[i] <= '0;
				rr_q[i] <= '0;
				sl_q[i] <= '0;
				ssg_en_q[i] <= 1'b0;
				ssg_eg_q[i] <= '0;
			end
		end else begin
			port_rdy_q <= 1'b1;
			if (fire) begin
				// write back the slot, pending keys consumed
				state_q[slot_q] <= state_next;
				att_q[slot_q] <= att_next;
				inv_q[slot_q] <= ssg_inv_out;
				lock_q[slot_q] <= ssg_lock_out;
				kon_q[slot_q] <= 1'b0;
				koff_q[slot_q] <= 1'b0;
				if (keyon_now) keyed_q[slot_q] <= 1'b1;
				if (keyoff_now) keyed_q[slot_q] <= 1'b0;
				slot_q <= slot_q + 1'b1; // wraps, power of two
				out_valid <= 1'b1;
			end
			// port set lands after the clear
			if (key_valid && port_rdy_q) begin
				if (key_on) kon_q[key_op] <= 1'b1;
				else koff_q[key_op] <= 1'b1;
			end
			if (cfg_valid && port_rdy_q) begin
				case (cfg_sel)
					3'd0: ar_q[cfg_op] <= cfg_data;
					3'd1: d1r_q[cfg_op] <= cfg_data;
					3'd2: d2r_q[cfg_op] <= cfg_data;
					3'd3: rr_q[cfg_op] <= cfg_data[3:0];
					3'd4: sl_q[cfg_op] <= cfg_data[3:0];
					3'd5: {ssg_en_q[cfg_op], ssg_eg_q[cfg_op]} <= cfg_data[3:0];
					default: ; // unused selects ignored
				endcase
			end
		end
	end

	// output payload, held while stalled
	always_ff @(posedge clk) begin
		if (fire) begin
			out_op <= slot_q;
			out_att <= level;
			out_pg_rst <= pg_rst;
		end
	end

endmodule

`default_nettype wire

// ==== eg_update.sv ====
`timescale 1ns/100ps
`default_nettype none

module eg_update import eg_pkg::*; (
	input  wire eg_state_t state, // phase this slot runs in
	input  wire eg_att_t   att,
	input  wire            step,
	input  wire [2:0]      inc,
	input  wire            ssg_en,
	input  wire            ssg_inv,
	input  wire eg_rate_t  arate,
	output eg_att_t        att_next,
	output eg_att_t        level
);

	eg_att_t dec;
	eg_att_t add;
	logic [$bits(eg_att_t):0] sum; // one spare bit to catch overflow

	always_comb begin
		// exponential attack, bigger bites while loud attenuation is high
		dec = ((att >> 4) + eg_att_t'(1)) * eg_att_t'(inc);
		// SSG runs its ramps four times faster
		add = ssg_en ? eg_att_t'({inc, 2'b00}) : eg_att_t'(inc);
		sum = {1'b0, att} + {1'b0, add};
		att_next = att;
		case (state)
			ATTACK: begin
				if (arate == 5'd31) begin
					att_next = '0; // instant attack
				end else if (step) begin
					att_next = (att > dec) ? att - dec : '0;
				end
			end
			DECAY, RELEASE: begin
				if (step) begin
					att_next = sum[$bits(eg_att_t)] ? ATT_MAX : sum[$bits(eg_att_t)-1:0];
				end
			end
			default: att_next = att; // hold
		endcase
	end

	// inverted SSG output mirrors around the halfway point
	always_comb begin
		if (!ssg_inv) begin
			level = att;
		end else if (att >= ATT_HALF) begin
			level = '0;
		end else begin
			level = ATT_HALF - att;
		end
	end

endmodule

`default_nettype wire

// ==== eg_step.sv ====
`timescale 1ns/100ps
`default_nettype none

module eg_step import eg_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           advance,   // one sample done
	input  wire eg_rate_t base_rate,
	output logic          step,
	output logic [2:0]    inc
);

	// slowest stepping rate waits 2^11 samples
	localparam logic [3:0] SHIFT_MAX = 4'd11;

	eg_cnt_t cnt_q;
	eg_cnt_t mask;
	logic [3:0] shift;

	// sample counter, shared by all operators
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (advance) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_comb begin
		// two rates per octave of step spacing
		shift = SHIFT_MAX - base_rate[4:1]; // only meaningful below 24
		mask = (eg_cnt_t'(1) << shift) - eg_cnt_t'(1);
		step = 1'b0;
		inc = 3'd1;
		if (base_rate >= 5'd28) begin
			step = 1'b1; // every sample, big steps
			inc = 3'd4;
		end else if (base_rate >= 5'd24) begin
			step = 1'b1;
			inc = 3'd2;
		end else if (base_rate != 5'd0) begin
			step = (cnt_q & mask) == '0; // low bits all clear
		end
	end

endmodule

`default_nettype wire

// ==== eg_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module eg_ctrl import eg_pkg::*; (
	input  wire            keyon_now,
	input  wire            keyoff_now,
	input  wire eg_state_t state_in,
	input  wire eg_att_t   att,
	// envelope rates
	input  wire eg_rate_t  arate, // attack
	input  wire eg_rate_t  rate1, // decay
	input  wire eg_rate_t  rate2, // sustain
	input  wire [3:0]      rrate, // release, expanded below
	input  wire [3:0]      sl,    // sustain level
	// SSG mode
	input  wire            ssg_en,
	input  wire [2:0]      ssg_eg, // attack, alternate, hold
	input  wire            ssg_inv_in,
	input  wire            ssg_lock_in,
	output logic           ssg_inv_out,
	output logic           ssg_lock_out,
	output eg_rate_t       base_rate,
	output eg_state_t      state_next,
	output logic           pg_rst
);

	logic [4:0] sustain;
	logic ssg_att;
	logic ssg_alt;
	logic ssg_hold;
	logic ssg_over;
	logic above_sl;

	always_comb begin
		sustain = (sl == 4'd15) ? 5'h1f : {1'b0, sl}; // top step spans to the floor
		above_sl = att[$bits(eg_att_t)-1 -: 5] >= sustain;
		ssg_att = ssg_eg[2];
		ssg_alt = ssg_eg[1];
		ssg_hold = ssg_eg[0] & ssg_en;
		ssg_over = ssg_en && (att >= ATT_HALF); // crossed halfway
		// phase restart on key-on, or on a plain repeating SSG wave
		pg_rst = keyon_now | (ssg_over & ~(ssg_alt | ssg_hold));
	end

	always_comb begin
		// default is to stay put
		base_rate = 5'd0;
		state_next = state_in;
		ssg_inv_out = ssg_inv_in;
		ssg_lock_out = ssg_lock_in;
		if (keyoff_now) begin // key-off beats everything
			base_rate = {rrate, 1'b1};
			state_next = RELEASE;
			ssg_inv_out = ssg_inv_in & ssg_en;
			ssg_lock_out = 1'b0;
		end else if (keyon_now) begin
			base_rate = arate;
			state_next = ATTACK;
			ssg_inv_out = ssg_att & ssg_en; // attack bit sets the start polarity
			ssg_lock_out = 1'b0;
		end else begin
			case (state_in)
				ATTACK: begin
					if (att == '0) begin // peak reached
						base_rate = ssg_lock_in ? 5'd0 : rate1;
						state_next = ssg_lock_in ? HOLD : DECAY;
						ssg_inv_out = ssg_en & (ssg_alt ^ ssg_inv_in); // alternate flips
						ssg_lock_out = ssg_hold;
					end else begin
						base_rate = arate;
					end
				end
				DECAY: begin
					if (ssg_over) begin
						// SSG wraps back into attack
						base_rate = arate;
						state_next = ATTACK;
						ssg_lock_out = ssg_hold;
					end else begin
						base_rate = above_sl ? rate2 : rate1; // sustain phase past sl
						ssg_lock_out = 1'b0;
					end
				end
				HOLD: begin
					base_rate = 5'd0; // frozen
					ssg_lock_out = 1'b1;
				end
				default: begin // release
					base_rate = {rrate, 1'b1};
					state_next = RELEASE;
					ssg_inv_out = 1'b0; // inversion dropped while fading out
					ssg_lock_out = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== eg_pkg.sv ====
`default_nettype none

`include "eg_defines.svh"

package eg_pkg;

	// envelope phase, release doubles as idle
	typedef enum logic [1:0] {
		RELEASE = 2'd0, // reset value
		ATTACK  = 2'd1,
		DECAY   = 2'd2, // covers sustain as well, rate2 past sl
		HOLD    = 2'd3  // SSG hold, level frozen
	} eg_state_t;

	typedef logic [`EG_ATT_W-1:0] eg_att_t; // attenuation
	typedef logic [4:0] eg_rate_t; // 0 freezes the envelope
	typedef logic [$clog2(`EG_OPS)-1:0] eg_op_t; // operator index
	typedef logic [`EG_CNT_W-1:0] eg_cnt_t; // sample counter

	// fully silent
	localparam eg_att_t ATT_MAX = '1;

	// SSG overflow threshold, also the pivot of the inverted output
	localparam eg_att_t ATT_HALF = eg_att_t'(1) << (`EG_ATT_W - 1);

endpackage

`default_nettype wire

// ==== eg_defines.svh ====
`ifndef EG_DEFINES_SVH
`define EG_DEFINES_SVH

// operators sharing one envelope datapath
// must stay a power of two, the slot index wraps on its own
`define EG_OPS 4

// attenuation in 10 bits
// 0 is full level, all ones is silence
`define EG_ATT_W 10

// global sample counter
// the slowest rates look at its low 11 bits
`define EG_CNT_W 12

`endif
